// ==== src/lut_ram.sv ====
////////////////////////////////////////////////////////////
// LUT RAM
// One synchronous write port, one asynchronous read port,
// word layout set by a type parameter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lut_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    // Storage, no reset
    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational
    assign rdata = mem[raddr];

endmodule

// ==== src/page_walker.sv ====
////////////////////////////////////////////////////////////
// Page walker
// Reads the single-level page table on a TLB miss, checks
// range, validity and permission, then returns the PPN or
// a fault cause
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module page_walker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              abort,
    mmu_walk_if.walker                        mmu,
    output logic [tlb_cfg_pkg::PT_IDX_W-1:0]  pt_addr_rd,
    input  tlb_types_pkg::pte_t               pt_rdata
);

    logic                          request_q;
    logic                          start;
    logic                          checking;
    // VPN bits above the table index
    logic [tlb_cfg_pkg::VADDR_W-1:tlb_cfg_pkg::PAGE_OFS_W+tlb_cfg_pkg::PT_IDX_W] vpn_high_q;
    logic                          rnw_q;
    logic                          execute_q;
    tlb_types_pkg::pte_t           pte_q;
    tlb_types_pkg::fault_cause_t   cause;
    logic                          perm_ok;

    ////////////////////////////////////////////////////////////
    // Walk control
    ////////////////////////////////////////////////////////////

    // Table indexed by the low VPN bits
    assign pt_addr_rd = mmu.virtual_address[tlb_cfg_pkg::PAGE_OFS_W +: tlb_cfg_pkg::PT_IDX_W];

    // New walk on the rising edge of request
    assign start = mmu.request & ~request_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            request_q <= 1'b0;
            checking  <= 1'b0;
        end else if (abort) begin
            request_q <= 1'b0;
            checking  <= 1'b0;
        end else begin
            request_q <= mmu.request;
            checking  <= start;
        end
    end

    // Table word and request attributes captured at start
    always_ff @(posedge clk) begin
        if (start) begin
            pte_q      <= pt_rdata;
            vpn_high_q <= mmu.virtual_address[tlb_cfg_pkg::VADDR_W-1:
                                              tlb_cfg_pkg::PAGE_OFS_W+tlb_cfg_pkg::PT_IDX_W];
            rnw_q      <= mmu.rnw;
            execute_q  <= mmu.execute;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks, in priority order
    ////////////////////////////////////////////////////////////

    // Execute needs X, otherwise R for reads and W for writes
    always_comb begin
        if (execute_q) begin
            perm_ok = pte_q.executable;
        end else if (rnw_q) begin
            perm_ok = pte_q.readable;
        end else begin
            perm_ok = pte_q.writable;
        end
    end

    always_comb begin
        cause = tlb_types_pkg::FAULT_NONE;
        // VPN outside the table
        if (|vpn_high_q) begin
            cause = tlb_types_pkg::FAULT_RANGE;
        end else if (!pte_q.valid) begin
            cause = tlb_types_pkg::FAULT_INVALID;
        end else if (!perm_ok) begin
            cause = tlb_types_pkg::FAULT_PERM;
        end
    end

    // One pulse in the check cycle, suppressed by abort
    assign mmu.write_entry = checking & ~abort & (cause == tlb_types_pkg::FAULT_NONE);
    assign mmu.is_fault    = checking & ~abort & (cause != tlb_types_pkg::FAULT_NONE);
    assign mmu.fault_cause = cause;
    assign mmu.upper_physical_address = pte_q.ppn;

endmodule

// ==== src/tlb_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// TLB configuration
// Address widths, TLB geometry and page table size
////////////////////////////////////////////////////////////

package tlb_cfg_pkg;

    // Address split, 4 KB pages
    localparam int VADDR_W    = 32;
    localparam int PADDR_W    = 32;
    localparam int PAGE_OFS_W = 12;
    localparam int PPN_W      = 20;

    // TLB geometry
    localparam int TLB_WAYS  = 2;
    localparam int TLB_DEPTH = 16;
    localparam int TLB_IDX_W = 4;
    localparam int TLB_TAG_W = 32 - 12 - TLB_IDX_W;

    // Single-level page table, covers VPN 0..255
    localparam int PT_DEPTH = 256;
    localparam int PT_IDX_W = 8;

endpackage

// ==== src/tlb_if.sv ====
////////////////////////////////////////////////////////////
// TLB interfaces
// Client request path into the lookup, and the miss path
// between the lookup and the page walker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tlb_req_if;
    // Request side
    logic [tlb_cfg_pkg::VADDR_W-1:0] virtual_address;
    logic                            rnw;
    logic                            execute;
    logic                            new_request;
    // Response side
    logic                            ready;
    logic                            done;
    logic                            is_fault;
    tlb_types_pkg::fault_cause_t     fault_cause;
    logic [tlb_cfg_pkg::PADDR_W-1:0] physical_address;

    modport lookup (
        input  virtual_address, rnw, execute, new_request,
        output ready, done, is_fault, fault_cause, physical_address
    );

    modport client (
        output virtual_address, rnw, execute, new_request,
        input  ready, done, is_fault, fault_cause, physical_address
    );
endinterface

interface mmu_walk_if;
    // Miss request, held as a level
    logic                            request;
    logic [tlb_cfg_pkg::VADDR_W-1:0] virtual_address;
    logic                            rnw;
    logic                            execute;
    // Walk result, one pulse per walk
    logic                            write_entry;
    logic                            is_fault;
    tlb_types_pkg::fault_cause_t     fault_cause;
    logic [tlb_cfg_pkg::PPN_W-1:0]   upper_physical_address;

    modport tlb (
        output request, virtual_address, rnw, execute,
        input  write_entry, is_fault, fault_cause, upper_physical_address
    );

    modport walker (
        input  request, virtual_address, rnw, execute,
        output write_entry, is_fault, fault_cause, upper_physical_address
    );
endinterface

// ==== src/tlb_lookup.sv ====
////////////////////////////////////////////////////////////
// TLB lookup control
// Same-cycle tag compare across all ways, miss tracking
// toward the page walker, refill writes into the victim way
// and the set-by-set flush sweep
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlb_lookup (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic                                 abort,
    tlb_req_if.lookup                            req,
    mmu_walk_if.tlb                              mmu,
    output logic [tlb_cfg_pkg::TLB_IDX_W-1:0]    ram_addr,
    output logic [tlb_cfg_pkg::TLB_WAYS-1:0]     ram_we,
    output tlb_types_pkg::tlb_entry_t            ram_wdata,
    input  tlb_types_pkg::tlb_entry_t            ram_rdata [tlb_cfg_pkg::TLB_WAYS],
    input  logic [tlb_cfg_pkg::TLB_WAYS-1:0]     victim_way
);

    logic [tlb_cfg_pkg::TLB_IDX_W-1:0] req_idx;
    logic [tlb_cfg_pkg::TLB_TAG_W-1:0] virtual_tag;
    logic [tlb_cfg_pkg::TLB_WAYS-1:0]  tag_hit;
    logic                              hit;
    logic                              idle;
    logic                              accept;
    logic                              miss_active;
    logic                              refill_we;
    logic                              refill_done;
    logic                              sweep_active;
    logic [tlb_cfg_pkg::TLB_IDX_W-1:0] sweep_idx;

    ////////////////////////////////////////////////////////////
    // Address split and tag compare
    ////////////////////////////////////////////////////////////

    assign req_idx     = req.virtual_address[tlb_cfg_pkg::PAGE_OFS_W +: tlb_cfg_pkg::TLB_IDX_W];
    assign virtual_tag = req.virtual_address[tlb_cfg_pkg::VADDR_W-1 -: tlb_cfg_pkg::TLB_TAG_W];

    // Sweep owns the RAM address while it runs
    assign ram_addr = sweep_active ? sweep_idx : req_idx;

    always_comb begin
        for (int w = 0; w < tlb_cfg_pkg::TLB_WAYS; w++) begin
            tag_hit[w] = ram_rdata[w].valid && (ram_rdata[w].tag == virtual_tag);
        end
    end

    assign hit = |tag_hit;

    // Page offset passes through, hit way supplies the PPN
    always_comb begin
        req.physical_address = '0;
        req.physical_address[tlb_cfg_pkg::PAGE_OFS_W-1:0] =
            req.virtual_address[tlb_cfg_pkg::PAGE_OFS_W-1:0];
        for (int w = 0; w < tlb_cfg_pkg::TLB_WAYS; w++) begin
            if (tag_hit[w]) begin
                req.physical_address[tlb_cfg_pkg::PADDR_W-1:tlb_cfg_pkg::PAGE_OFS_W] |=
                    ram_rdata[w].ppn;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Request handshake and miss tracking
    ////////////////////////////////////////////////////////////

    // Busy during a walk, the refill done cycle and a sweep
    assign idle      = ~(miss_active | refill_done | sweep_active);
    assign req.ready = idle;

    // Requests while busy are dropped
    assign accept = req.new_request & idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_active <= 1'b0;
        end else if (abort | mmu.write_entry | mmu.is_fault) begin
            miss_active <= 1'b0;
        end else if (accept & ~hit) begin
            miss_active <= 1'b1;
        end
    end

    // Walker entry lands in the victim way
    assign refill_we = mmu.write_entry & miss_active & ~sweep_active;

    // Entry is readable one cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_done <= 1'b0;
        end else begin
            refill_done <= refill_we;
        end
    end

    assign req.done        = hit & (accept | refill_done);
    assign req.is_fault    = mmu.is_fault & miss_active;
    assign req.fault_cause = mmu.fault_cause;

    // Miss path to the walker
    assign mmu.request         = miss_active;
    assign mmu.virtual_address = req.virtual_address;
    assign mmu.rnw             = req.rnw;
    assign mmu.execute         = req.execute;

    ////////////////////////////////////////////////////////////
    // Flush sweep
    ////////////////////////////////////////////////////////////

    // One set per cycle, TLB_DEPTH cycles in total
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_active <= 1'b0;
            sweep_idx    <= '0;
        end else if (flush) begin
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
        end else if (sweep_active) begin
            sweep_idx <= sweep_idx + 1'b1;
            // Depth is a power of two, last set is all ones
            if (&sweep_idx) begin
                sweep_active <= 1'b0;
            end
        end
    end

    // All ways cleared together during the sweep
    always_comb begin
        if (sweep_active) begin
            ram_we = '1;
        end else if (refill_we) begin
            ram_we = victim_way;
        end else begin
            ram_we = '0;
        end
    end

    assign ram_wdata.valid = ~sweep_active;
    assign ram_wdata.tag   = virtual_tag;
    assign ram_wdata.ppn   = mmu.upper_physical_address;

endmodule

// ==== src/tlb_top.sv ====
////////////////////////////////////////////////////////////
// TLB subsystem top
// Lookup control, page walker, way RAMs, page table RAM
// and the replacement cycler behind plain ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlb_top (
    input  logic                              clk,
    input  logic                              rst,
    // Translation request
    input  logic [tlb_cfg_pkg::VADDR_W-1:0]   virtual_address,
    input  logic                              rnw,
    input  logic                              execute,
    input  logic                              new_request,
    output logic                              ready,
    output logic                              done,
    output logic                              is_fault,
    output tlb_types_pkg::fault_cause_t       fault_cause,
    output logic [tlb_cfg_pkg::PADDR_W-1:0]   physical_address,
    // Control
    input  logic                              flush,
    input  logic                              abort,
    // Page table load port
    input  logic                              pt_we,
    input  logic [tlb_cfg_pkg::PT_IDX_W-1:0]  pt_addr,
    input  tlb_types_pkg::pte_t               pt_wdata
);

    tlb_req_if  req_bus ();
    mmu_walk_if walk_bus ();

    logic [tlb_cfg_pkg::TLB_IDX_W-1:0] ram_addr;
    logic [tlb_cfg_pkg::TLB_WAYS-1:0]  ram_we;
    tlb_types_pkg::tlb_entry_t         ram_wdata;
    tlb_types_pkg::tlb_entry_t         ram_rdata [tlb_cfg_pkg::TLB_WAYS];
    logic [tlb_cfg_pkg::TLB_WAYS-1:0]  victim_way;
    logic [tlb_cfg_pkg::PT_IDX_W-1:0]  pt_addr_rd;
    tlb_types_pkg::pte_t               pt_rdata;

    // Client side of the request bundle
    assign req_bus.virtual_address = virtual_address;
    assign req_bus.rnw             = rnw;
    assign req_bus.execute         = execute;
    assign req_bus.new_request     = new_request;
    assign ready            = req_bus.ready;
    assign done             = req_bus.done;
    assign is_fault         = req_bus.is_fault;
    assign fault_cause      = req_bus.fault_cause;
    assign physical_address = req_bus.physical_address;

    tlb_lookup i_tlb_lookup (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .abort      (abort),
        .req        (req_bus.lookup),
        .mmu        (walk_bus.tlb),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .victim_way (victim_way)
    );

    page_walker i_page_walker (
        .clk        (clk),
        .rst        (rst),
        .abort      (abort),
        .mmu        (walk_bus.walker),
        .pt_addr_rd (pt_addr_rd),
        .pt_rdata   (pt_rdata)
    );

    // Victim moves on after each refill
    way_cycler i_way_cycler (
        .clk     (clk),
        .rst     (rst),
        .advance (walk_bus.write_entry),
        .one_hot (victim_way)
    );

    // One RAM per TLB way, shared address
    for (genvar w = 0; w < tlb_cfg_pkg::TLB_WAYS; w++) begin : g_way
        lut_ram #(
            .word_t (tlb_types_pkg::tlb_entry_t),
            .DEPTH  (tlb_cfg_pkg::TLB_DEPTH)
        ) i_way_ram (
            .clk   (clk),
            .we    (ram_we[w]),
            .waddr (ram_addr),
            .wdata (ram_wdata),
            .raddr (ram_addr),
            .rdata (ram_rdata[w])
        );
    end

    // Page table, loaded by the host
    lut_ram #(
        .word_t (tlb_types_pkg::pte_t),
        .DEPTH  (tlb_cfg_pkg::PT_DEPTH)
    ) i_pt_ram (
        .clk   (clk),
        .we    (pt_we),
        .waddr (pt_addr),
        .wdata (pt_wdata),
        .raddr (pt_addr_rd),
        .rdata (pt_rdata)
    );

endmodule

// ==== src/tlb_types_pkg.sv ====
////////////////////////////////////////////////////////////
// TLB data types
// Stored TLB entry, page table entry and fault codes
////////////////////////////////////////////////////////////

package tlb_types_pkg;

    // One TLB way entry
    typedef struct packed {
        logic                               valid;
        logic [tlb_cfg_pkg::TLB_TAG_W-1:0]  tag;
        logic [tlb_cfg_pkg::PPN_W-1:0]      ppn;
    } tlb_entry_t;

    // Page table entry as loaded by the host
    typedef struct packed {
        logic                           valid;
        logic                           readable;
        logic                           writable;
        logic                           executable;
        logic [tlb_cfg_pkg::PPN_W-1:0]  ppn;
    } pte_t;

    // Fault reported back to the client
    typedef enum logic [1:0] {
        FAULT_NONE    = 2'd0,
        FAULT_INVALID = 2'd1,
        FAULT_RANGE   = 2'd2,
        FAULT_PERM    = 2'd3
    } fault_cause_t;

endpackage

// ==== src/way_cycler.sv ====
////////////////////////////////////////////////////////////
// Way cycler
// One-hot round-robin pointer to the next victim way
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module way_cycler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             advance,
    output logic [tlb_cfg_pkg::TLB_WAYS-1:0] one_hot
);

    // Rotate left by one on every refill
    always_ff @(posedge clk) begin
        if (rst) begin
            one_hot <= {{(tlb_cfg_pkg::TLB_WAYS-1){1'b0}}, 1'b1};
        end else if (advance) begin
            one_hot <= {one_hot[tlb_cfg_pkg::TLB_WAYS-2:0],
                        one_hot[tlb_cfg_pkg::TLB_WAYS-1]};
        end
    end

endmodule

// ==== tb.f ====
src/tlb_cfg_pkg.sv
src/tlb_types_pkg.sv
src/tlb_if.sv
src/lut_ram.sv
src/way_cycler.sv
src/tlb_lookup.sv
src/page_walker.sv
src/tlb_top.sv
tb/tlb_tb.sv

// ==== tb/tlb_tb.sv ====
////////////////////////////////////////////////////////////
// TLB subsystem testbench
// Random page table model, directed faults, flush, abort
// and hit reuse, checked by concurrent assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlb_tb;

    localparam int CLK_PERIOD = 4;
    localparam int REQ_COUNT  = 220;
    localparam int WATCHDOG_CYCLES = REQ_COUNT * 10 + 2 * (tlb_cfg_pkg::PT_DEPTH + 2)
                                     + 5 * (tlb_cfg_pkg::TLB_DEPTH + 4) + 20;

    logic                            clk = 1'b0;
    logic                            rst;
    logic [tlb_cfg_pkg::VADDR_W-1:0] virtual_address;
    logic                            rnw;
    logic                            execute;
    logic                            new_request;
    logic                            ready;
    logic                            done;
    logic                            is_fault;
    tlb_types_pkg::fault_cause_t     fault_cause;
    logic [tlb_cfg_pkg::PADDR_W-1:0] physical_address;
    logic                            flush;
    logic                            abort;
    logic                            pt_we;
    logic [tlb_cfg_pkg::PT_IDX_W-1:0] pt_addr;
    tlb_types_pkg::pte_t             pt_wdata;

    // Reference copy of the page table
    tlb_types_pkg::pte_t pt_model [tlb_cfg_pkg::PT_DEPTH];

    int   seed = 70;
    int   value_errors = 0;
    int   other_errors = 0;
    logic expect_hit = 1'b0;
    logic outstanding;
    int   flush_left;
    logic flush_tail;

    tlb_top i_tlb_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Expected results from the page table rules
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] expected_pa(input logic [31:0] va);
        return {pt_model[va[tlb_cfg_pkg::PAGE_OFS_W +: tlb_cfg_pkg::PT_IDX_W]].ppn,
                va[tlb_cfg_pkg::PAGE_OFS_W-1:0]};
    endfunction

    function automatic tlb_types_pkg::fault_cause_t expected_cause(
        input logic [31:0] va, input logic rd, input logic ex);
        logic [19:0]         vpn;
        tlb_types_pkg::pte_t pte;
        logic                allowed;
        vpn = va[31:12];
        pte = pt_model[vpn[7:0]];
        // Execute wins over read or write
        allowed = ex ? pte.executable : (rd ? pte.readable : pte.writable);
        if (vpn >= tlb_cfg_pkg::PT_DEPTH) return tlb_types_pkg::FAULT_RANGE;
        if (!pte.valid) return tlb_types_pkg::FAULT_INVALID;
        if (!allowed) return tlb_types_pkg::FAULT_PERM;
        return tlb_types_pkg::FAULT_NONE;
    endfunction

    // Open request, so that every response has exactly one owner
    always @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (abort || done || is_fault) begin
            outstanding <= 1'b0;
        end else if (new_request && ready) begin
            outstanding <= 1'b1;
        end
    end

    // Cycles left in the flush sweep
    always @(posedge clk) begin
        if (rst) begin
            flush_left <= 0;
            flush_tail <= 1'b0;
        end else begin
            flush_tail <= (flush_left == 1);
            if (flush) begin
                flush_left <= tlb_cfg_pkg::TLB_DEPTH;
            end else if (flush_left != 0) begin
                flush_left <= flush_left - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    pa_check: assert property (@(posedge clk) disable iff (rst)
        done |-> physical_address == expected_pa(virtual_address))
    else begin
        value_errors++;
        $display("ERROR physical_address got %h expected %h", $sampled(physical_address),
                 expected_pa($sampled(virtual_address)));
    end

    done_allowed: assert property (@(posedge clk) disable iff (rst)
        done |-> expected_cause(virtual_address, rnw, execute) == tlb_types_pkg::FAULT_NONE)
    else begin
        value_errors++;
        $display("ERROR done got %h expected %h", 1'b1, 1'b0);
    end

    cause_check: assert property (@(posedge clk) disable iff (rst)
        is_fault |-> fault_cause == expected_cause(virtual_address, rnw, execute))
    else begin
        value_errors++;
        $display("ERROR fault_cause got %h expected %h", $sampled(fault_cause),
                 expected_cause($sampled(virtual_address), $sampled(rnw), $sampled(execute)));
    end

    one_response: assert property (@(posedge clk) disable iff (rst) !(done && is_fault))
    else begin
        other_errors++;
        $display("done and is_fault were raised together");
    end

    response_owner: assert property (@(posedge clk) disable iff (rst)
        (done || is_fault) |-> (outstanding || (new_request && ready)))
    else begin
        other_errors++;
        $display("Response seen with no open request");
    end

    hit_check: assert property (@(posedge clk) disable iff (rst)
        (new_request && expect_hit) |-> done)
    else begin
        value_errors++;
        $display("ERROR done got %h expected %h", $sampled(done), 1'b1);
    end

    flush_busy: assert property (@(posedge clk) disable iff (rst) (flush_left != 0) |-> !ready)
    else begin
        value_errors++;
        $display("ERROR ready got %h expected %h", $sampled(ready), 1'b0);
    end

    flush_end: assert property (@(posedge clk) disable iff (rst) flush_tail |-> ready)
    else begin
        value_errors++;
        $display("ERROR ready got %h expected %h", $sampled(ready), 1'b1);
    end

    abort_ready: assert property (@(posedge clk) disable iff (rst) abort |=> ready)
    else begin
        value_errors++;
        $display("ERROR ready got %h expected %h", $sampled(ready), 1'b1);
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic fill_model();
        logic [31:0] r;
        for (int i = 0; i < tlb_cfg_pkg::PT_DEPTH; i++) begin
            r = $random(seed);
            pt_model[i] = r[23:0];
            pt_model[i].valid = |r[31:30];
        end
        // Fixed permissions for the directed pages, PPNs stay random
        pt_model[1][23:20] = 4'b1111;
        pt_model[2].valid  = 1'b0;
        pt_model[3][23:20] = 4'b1100;
        pt_model[4][23:20] = 4'b1010;
        pt_model[5][23:20] = 4'b1100;
        pt_model[21][23:20] = 4'b1100;
    endtask

    task automatic load_table();
        for (int i = 0; i < tlb_cfg_pkg::PT_DEPTH; i++) begin
            @(posedge clk);
            #1;
            pt_we    = 1'b1;
            pt_addr  = i[tlb_cfg_pkg::PT_IDX_W-1:0];
            pt_wdata = pt_model[i];
        end
        @(posedge clk);
        #1;
        pt_we = 1'b0;
    endtask

    task automatic flush_tlb();
        int waited;
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        // Dropped while the sweep runs
        virtual_address = 32'h0000_1000;
        rnw             = 1'b1;
        execute         = 1'b0;
        new_request     = 1'b1;
        @(posedge clk);
        #1;
        new_request = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!ready && waited < tlb_cfg_pkg::TLB_DEPTH + 4) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            other_errors++;
            $display("Flush sweep did not release ready");
        end
    endtask

    task automatic translate(input logic [31:0] va, input logic rd, input logic ex,
                             input logic hit);
        int waited;
        @(posedge clk);
        #1;
        virtual_address = va;
        rnw             = rd;
        execute         = ex;
        new_request     = 1'b1;
        expect_hit      = hit;
        waited = 0;
        @(negedge clk);
        while (!(done || is_fault) && waited < 10) begin
            @(posedge clk);
            #1;
            new_request = 1'b0;
            expect_hit  = 1'b0;
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #1;
        new_request = 1'b0;
        expect_hit  = 1'b0;
        if (waited >= 10) begin
            other_errors++;
            $display("Request to %h got neither done nor fault", va);
        end
    endtask

    // Miss that is cancelled before or during the page table check
    task automatic abort_miss(input logic [31:0] va, input int late);
        @(posedge clk);
        #1;
        virtual_address = va;
        rnw             = 1'b1;
        execute         = 1'b0;
        new_request     = 1'b1;
        @(posedge clk);
        #1;
        new_request = 1'b0;
        repeat (late) begin
            @(posedge clk);
            #1;
        end
        abort = 1'b1;
        @(posedge clk);
        #1;
        abort = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic directed_faults();
        translate(32'h0000_2123, 1'b1, 1'b0, 1'b0);
        translate(32'h0000_3456, 1'b0, 1'b0, 1'b0);
        translate(32'h0000_3456, 1'b1, 1'b1, 1'b0);
        translate(32'h0000_4789, 1'b1, 1'b0, 1'b0);
        translate(32'h0010_0abc, 1'b1, 1'b0, 1'b0);
        translate(32'hffff_f000, 1'b0, 1'b0, 1'b0);
        // Allowed accesses after the faults, miss then hit
        translate(32'h0000_3456, 1'b1, 1'b0, 1'b0);
        translate(32'h0000_3fff, 1'b1, 1'b0, 1'b1);
        translate(32'h0000_4001, 1'b0, 1'b0, 1'b0);
        translate(32'h0000_4002, 1'b0, 1'b0, 1'b1);
    endtask

    // Two pages sharing set 5 fit in the two ways
    task automatic set_reuse();
        translate(32'h0000_5010, 1'b1, 1'b0, 1'b0);
        translate(32'h0001_5020, 1'b1, 1'b0, 1'b0);
        translate(32'h0000_5030, 1'b1, 1'b0, 1'b1);
        translate(32'h0001_5040, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic random_pass(input int count);
        logic [31:0]         r;
        logic [19:0]         vpn;
        logic [31:0]         va;
        logic                rd;
        logic                ex;
        tlb_types_pkg::pte_t pte;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            // About one in eight beyond the table
            vpn = (r[31:29] == 3'd0) ? 20'h00100 + r[15:0] : {12'h0, r[7:0]};
            va  = {vpn, r[27:16]};
            pte = pt_model[vpn[7:0]];
            // Execute-only pages always execute so cached pages see only allowed accesses
            ex = pte.valid & pte.executable & (r[28] | ~(pte.readable | pte.writable));
            rd = ex | pte.readable | (~pte.writable & r[20]);
            translate(va, rd, ex, 1'b0);
            if (expected_cause(va, rd, ex) == tlb_types_pkg::FAULT_NONE) begin
                translate(va, rd, ex, 1'b1);
            end
        end
    endtask

    task automatic report_counts();
        $display("Checks finished with %0d value errors and %0d other errors",
                 value_errors, other_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst             = 1'b1;
        virtual_address = '0;
        rnw             = 1'b1;
        execute         = 1'b0;
        new_request     = 1'b0;
        flush           = 1'b0;
        abort           = 1'b0;
        pt_we           = 1'b0;
        pt_addr         = '0;
        pt_wdata        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // First table
        fill_model();
        load_table();
        flush_tlb();
        directed_faults();
        set_reuse();
        random_pass(40);

        // Abort before and during the table check
        flush_tlb();
        abort_miss(32'h0000_1234, 0);
        translate(32'h0000_1234, 1'b1, 1'b0, 1'b0);
        flush_tlb();
        abort_miss(32'h0000_1234, 1);
        translate(32'h0000_1234, 1'b1, 1'b0, 1'b0);
        translate(32'h0000_1238, 1'b0, 1'b0, 1'b1);

        // Rewritten table, old entries must not survive the flush
        fill_model();
        load_table();
        flush_tlb();
        // Page 1 was cached under the old table
        translate(32'h0000_1234, 1'b1, 1'b0, 1'b0);
        directed_faults();
        random_pass(40);

        repeat (4) @(posedge clk);
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the request count, loads and flushes
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        report_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
